// ==== rv_pipe.f ====
+incdir+common
common/rv_pipe_pkg.sv
rtl/fetch_control.sv
decode/reg_file.sv
decode/decode_stage.sv
execute/execute_stage.sv
rtl/result_stage.sv
rtl/rv_pipe_top.sv
tests/tb_rv_pipe.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the rv_pipe testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f rv_pipe.f --top-module tb_rv_pipe -Mdir "$build_dir" -o tb_rv_pipe
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$build_dir/tb_rv_pipe" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Simulation finished: FAIL" "$log_file"; then
    exit 1
fi
if ! grep -q "Simulation finished: PASS" "$log_file"; then
    echo "No pass line found in $log_file"
    exit 1
fi
exit 0

// ==== tests/tb_rv_pipe.sv ====
`include "rv_pipe_consts.svh"

module tb_rv_pipe;
    timeunit 1ns;
    timeprecision 1ps;

    import rv_pipe_pkg::*;

    localparam int    PROG_LEN        = 29;
    localparam int    WATCHDOG_CYCLES = PROG_LEN * 20;
    localparam int    N_STORES        = 8;
    localparam word_t ROM_LIMIT       = 32'h0000_0100;
    localparam word_t MARKER_A        = 32'h0000_0180;
    localparam word_t MARKER_B        = 32'h0000_0184;

    logic   clk     = 1'b0;
    logic   i_reset = 1'b1;
    word_t  i_idt;
    logic   i_acki  = 1'b0;
    word_t  i_ddt   = '0;
    logic   i_ackd  = 1'b0;
    word_t  o_iad;
    word_t  o_dad;
    word_t  o_ddt;
    logic   o_mreq;
    logic   o_write;

    word_t  rom      [0:63];
    word_t  dmem     [0:255];
    word_t  exp_addr [0:N_STORES-1];
    word_t  exp_data [0:N_STORES-1];
    integer seed = 32'h35805267;
    int     fetch_delay;
    int     fetch_left;
    int     data_delay;
    int     data_left;
    logic   data_busy;
    int     store_count     = 0;
    int     value_errors    = 0;
    int     protocol_errors = 0;

    always #5 clk = ~clk;

    rv_pipe_top i_dut (
        .clk    (clk),
        .i_reset(i_reset),
        .o_iad  (o_iad),
        .i_idt  (i_idt),
        .i_acki (i_acki),
        .o_dad  (o_dad),
        .o_ddt  (o_ddt),
        .i_ddt  (i_ddt),
        .o_mreq (o_mreq),
        .o_write(o_write),
        .i_ackd (i_ackd)
    );

    // Instruction encoders
    function automatic word_t r_format(logic [6:0] funct7, reg_addr_t rs2, reg_addr_t rs1,
                                       logic [2:0] funct3, reg_addr_t rd);
        return {funct7, rs2, rs1, funct3, rd, `OP_REG};
    endfunction

    function automatic word_t i_format(logic [11:0] imm, reg_addr_t rs1, logic [2:0] funct3,
                                       reg_addr_t rd, logic [6:0] opcode);
        return {imm, rs1, funct3, rd, opcode};
    endfunction

    function automatic word_t s_format(logic [11:0] imm, reg_addr_t rs2, reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, `F3_WORD, imm[4:0], `OP_STORE};
    endfunction

    function automatic word_t b_format(logic [12:0] imm, reg_addr_t rs2, reg_addr_t rs1,
                                       logic [2:0] funct3);
        return {imm[12], imm[10:5], rs2, rs1, funct3, imm[4:1], imm[11], `OP_BRANCH};
    endfunction

    function automatic word_t u_format(logic [19:0] imm, reg_addr_t rd);
        return {imm, rd, `OP_LUI};
    endfunction

    function automatic word_t j_format(logic [20:0] imm, reg_addr_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `OP_JAL};
    endfunction

    function automatic word_t fill_word(word_t addr);
        return 32'h5A00_0000 | addr;
    endfunction

    task automatic check_store(word_t addr, word_t data);
        assert (addr != MARKER_A && addr != MARKER_B) else begin
            value_errors++;
            $display("Store to marker address %h, a skipped instruction was executed", addr);
        end
        assert (store_count < N_STORES) else begin
            value_errors++;
            $display("More stores than the program contains, extra one to %h", addr);
        end
        if (store_count < N_STORES) begin
            assert (addr == exp_addr[store_count]) else begin
                value_errors++;
                $display("Fail at %0t: o_dad = %h, expected %h",
                         $time, addr, exp_addr[store_count]);
            end
            assert (data == exp_data[store_count]) else begin
                value_errors++;
                $display("Fail at %0t: o_ddt = %h, expected %h",
                         $time, data, exp_data[store_count]);
            end
        end
        store_count++;
    endtask

    // Asynchronous ROM read, the wait model below decides when it is acknowledged
    assign i_idt = (o_iad < ROM_LIMIT) ? rom[o_iad[7:2]] : '0;

    // Both memory models share one process so the random sequence is fixed
    always @(posedge clk) begin
        if (i_reset) begin
            i_acki     <= 1'b1;
            fetch_left <= 0;
        end else if (i_acki && !(o_mreq && !i_ackd)) begin
            // Word taken, the next address gets a fresh wait
            fetch_delay = $unsigned($random(seed)) % 3;
            i_acki     <= (fetch_delay == 0);
            fetch_left <= fetch_delay;
        end else if (!i_acki) begin
            if (fetch_left == 1) begin
                i_acki <= 1'b1;
            end
            fetch_left <= fetch_left - 1;
        end

        if (i_reset) begin
            i_ackd    <= 1'b0;
            i_ddt     <= '0;
            data_busy <= 1'b0;
            data_left <= 0;
            for (int i = 0; i < 256; i++) begin
                dmem[i] <= fill_word(word_t'(i << 2));
            end
        end else if (i_ackd) begin
            i_ackd <= 1'b0;
        end else if (o_mreq) begin
            if (data_busy) begin
                data_delay = data_left;
            end else begin
                data_delay = $unsigned($random(seed)) % 3;
            end
            data_busy <= 1'b1;
            if (data_delay == 0) begin
                i_ackd    <= 1'b1;
                data_busy <= 1'b0;
                if (o_write) begin
                    check_store(o_dad, o_ddt);
                    dmem[o_dad[9:2]] <= o_ddt;
                end else begin
                    i_ddt <= dmem[o_dad[9:2]];
                end
            end else begin
                data_left <= data_delay - 1;
            end
        end
    end

    a_reset_idle: assert property (@(posedge clk)
        i_reset |=> (!o_mreq && !o_write && o_iad == 32'h0))
        else begin
            protocol_errors++;
            $display("Outputs not idle with o_iad at zero after a reset edge at %0t", $time);
        end

    a_fetch_steady: assert property (@(posedge clk) disable iff (i_reset)
        !i_acki |=> $stable(o_iad))
        else begin
            protocol_errors++;
            $display("o_iad changed while i_acki was low at %0t", $time);
        end

    a_data_steady: assert property (@(posedge clk) disable iff (i_reset)
        (o_mreq && !i_ackd) |=>
            (o_mreq && $stable(o_dad) && $stable(o_ddt) && $stable(o_write)))
        else begin
            protocol_errors++;
            $display("Data request dropped or changed before i_ackd at %0t", $time);
        end

    initial begin
        for (int i = 0; i < 64; i++) begin
            rom[i] = '0;
        end
        // Dependent ALU chain
        rom[0]  = u_format(20'h12345, 5'd1);
        rom[1]  = i_format(12'h678, 5'd1, `F3_ADD, 5'd1, `OP_IMM);
        rom[2]  = i_format(12'h0FF, 5'd1, `F3_XOR, 5'd2, `OP_IMM);
        rom[3]  = r_format(`F7_BASE, 5'd1, 5'd2, `F3_ADD, 5'd3);
        rom[4]  = r_format(`F7_SUB, 5'd1, 5'd3, `F3_ADD, 5'd4);
        rom[5]  = i_format(12'h7F0, 5'd4, `F3_AND, 5'd5, `OP_IMM);
        rom[6]  = r_format(`F7_BASE, 5'd3, 5'd5, `F3_OR, 5'd5);
        rom[7]  = r_format(`F7_BASE, 5'd5, 5'd1, `F3_SLT, 5'd6);
        rom[8]  = i_format(12'd2, 5'd6, `F3_SLT, 5'd7, `OP_IMM);
        rom[9]  = s_format(12'h100, 5'd3, 5'd0);
        rom[10] = s_format(12'h104, 5'd4, 5'd0);
        rom[11] = s_format(12'h108, 5'd5, 5'd0);
        rom[12] = s_format(12'h10C, 5'd7, 5'd0);
        // Load then immediate use
        rom[13] = i_format(12'h200, 5'd0, `F3_WORD, 5'd8, `OP_LOAD);
        rom[14] = r_format(`F7_BASE, 5'd7, 5'd8, `F3_ADD, 5'd9);
        rom[15] = s_format(12'h110, 5'd9, 5'd0);
        // x0 stays zero
        rom[16] = i_format(12'h055, 5'd0, `F3_ADD, 5'd0, `OP_IMM);
        rom[17] = s_format(12'h114, 5'd0, 5'd0);
        // Counting loop, then BEQ and JAL over marker stores
        rom[18] = i_format(12'd0, 5'd0, `F3_ADD, 5'd10, `OP_IMM);
        rom[19] = i_format(12'd5, 5'd0, `F3_ADD, 5'd11, `OP_IMM);
        rom[20] = i_format(12'd1, 5'd10, `F3_ADD, 5'd10, `OP_IMM);
        rom[21] = b_format(-13'sd4, 5'd11, 5'd10, `F3_BNE);
        rom[22] = s_format(12'h118, 5'd10, 5'd0);
        rom[23] = b_format(13'd8, 5'd11, 5'd10, `F3_BEQ);
        rom[24] = s_format(12'h180, 5'd1, 5'd0);
        rom[25] = j_format(21'd8, 5'd12);
        rom[26] = s_format(12'h184, 5'd1, 5'd0);
        rom[27] = s_format(12'h11C, 5'd12, 5'd0);
        rom[28] = j_format(21'd0, 5'd0);

        // Worked out by hand from the ISA
        exp_addr[0] = 32'h0000_0100;
        exp_data[0] = 32'h2468_ACFF;
        exp_addr[1] = 32'h0000_0104;
        exp_data[1] = 32'h1234_5687;
        exp_addr[2] = 32'h0000_0108;
        exp_data[2] = 32'h2468_AEFF;
        exp_addr[3] = 32'h0000_010C;
        exp_data[3] = 32'h0000_0001;
        // Fill value at 0x200 plus one
        exp_addr[4] = 32'h0000_0110;
        exp_data[4] = 32'h5A00_0201;
        exp_addr[5] = 32'h0000_0114;
        exp_data[5] = 32'h0000_0000;
        exp_addr[6] = 32'h0000_0118;
        exp_data[6] = 32'h0000_0005;
        // Link of the JAL at 0x64
        exp_addr[7] = 32'h0000_011C;
        exp_data[7] = 32'h0000_0068;

        repeat (5) @(posedge clk);
        i_reset <= 1'b0;

        while (store_count < N_STORES) begin
            @(posedge clk);
        end
        // A few more cycles so a stray store would still show up
        repeat (8) @(posedge clk);

        $display("Errors: %0d value, %0d protocol, %0d of %0d stores seen",
                 value_errors, protocol_errors, store_count, N_STORES);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout after %0d cycles with %0d of %0d stores seen",
                 WATCHDOG_CYCLES, store_count, N_STORES);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

// ==== rtl/rv_pipe_top.sv ====
module rv_pipe_top (
    input  logic               clk,
    input  logic               i_reset,

    // Instruction memory
    output rv_pipe_pkg::word_t o_iad,
    input  rv_pipe_pkg::word_t i_idt,
    input  logic               i_acki,

    // Data memory
    output rv_pipe_pkg::word_t o_dad,
    output rv_pipe_pkg::word_t o_ddt,
    input  rv_pipe_pkg::word_t i_ddt,
    output logic               o_mreq,
    output logic               o_write,
    input  logic               i_ackd
);
    import rv_pipe_pkg::*;

    logic    hold;
    logic    flush;
    logic    mem_wait;
    logic    redirect;
    word_t   target;
    dec_ex_t dec;
    ex_res_t res;
    wb_t     wb;

    fetch_control fetch_control_inst (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_acki    (i_acki),
        .i_mem_wait(mem_wait),
        .i_redirect(redirect),
        .i_target  (target),
        .o_pc      (o_iad),
        .o_hold    (hold),
        .o_flush   (flush)
    );

    decode_stage decode_stage_inst (
        .clk    (clk),
        .i_reset(i_reset),
        .i_instr(i_idt),
        .i_pc   (o_iad),
        .i_hold (hold),
        .i_flush(flush),
        .i_wb   (wb),
        .o_dec  (dec)
    );

    execute_stage execute_stage_inst (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_dec     (dec),
        .i_wb      (wb),
        .i_hold    (hold),
        .o_res     (res),
        .o_redirect(redirect),
        .o_target  (target)
    );

    result_stage result_stage_inst (
        .i_res     (res),
        .i_ddt     (i_ddt),
        .i_ackd    (i_ackd),
        .o_dad     (o_dad),
        .o_ddt     (o_ddt),
        .o_mreq    (o_mreq),
        .o_write   (o_write),
        .o_mem_wait(mem_wait),
        .o_wb      (wb)
    );

endmodule

// ==== rtl/result_stage.sv ====
module result_stage (
    input  rv_pipe_pkg::ex_res_t i_res,
    input  rv_pipe_pkg::word_t   i_ddt,
    input  logic                 i_ackd,
    output rv_pipe_pkg::word_t   o_dad,
    output rv_pipe_pkg::word_t   o_ddt,
    output logic                 o_mreq,
    output logic                 o_write,
    output logic                 o_mem_wait,
    output rv_pipe_pkg::wb_t     o_wb
);

    logic mem_op;

    assign mem_op = i_res.valid && (i_res.is_load || i_res.is_store);

    // Strobes stay up until the acknowledge, the stage register is frozen meanwhile
    assign o_mreq     = mem_op;
    assign o_write    = i_res.valid && i_res.is_store;
    assign o_dad      = i_res.alu_result;
    assign o_ddt      = i_res.store_data;
    assign o_mem_wait = mem_op && !i_ackd;

    // Load data is only valid in the acknowledge cycle
    assign o_wb.we   = i_res.valid && i_res.reg_write && (!mem_op || i_ackd);
    assign o_wb.rd   = i_res.rd;
    assign o_wb.data = i_res.is_load ? i_ddt : i_res.alu_result;

    always_comb begin
        assert (!o_write || o_mreq)
            else $error("o_write raised without o_mreq");
    end

endmodule

// ==== execute/execute_stage.sv ====
`include "rv_pipe_consts.svh"

module execute_stage (
    input  logic                 clk,
    input  logic                 i_reset,
    input  rv_pipe_pkg::dec_ex_t i_dec,
    input  rv_pipe_pkg::wb_t     i_wb,
    input  logic                 i_hold,
    output rv_pipe_pkg::ex_res_t o_res,
    output logic                 o_redirect,
    output rv_pipe_pkg::word_t   o_target
);
    import rv_pipe_pkg::*;

    word_t   src1;
    word_t   src2;
    word_t   op_b;
    word_t   alu_out;
    word_t   link;
    logic    taken;
    ex_res_t res_d;

    // Take the result stage value when it writes the register we read
    function automatic word_t fwd_operand(reg_addr_t addr, word_t value, wb_t wb);
        word_t result;
        result = value;
        if (wb.we && wb.rd != '0 && wb.rd == addr) begin
            result = wb.data;
        end
        return result;
    endfunction

    assign src1 = fwd_operand(i_dec.rs1, i_dec.rs1_val, i_wb);
    assign src2 = fwd_operand(i_dec.rs2, i_dec.rs2_val, i_wb);
    assign op_b = i_dec.use_imm ? i_dec.imm : src2;

    always_comb begin
        case (i_dec.alu_op)
            `ALU_ADD:   alu_out = src1 + op_b;
            `ALU_SUB:   alu_out = src1 - op_b;
            `ALU_AND:   alu_out = src1 & op_b;
            `ALU_OR:    alu_out = src1 | op_b;
            `ALU_XOR:   alu_out = src1 ^ op_b;
            `ALU_SLT:   alu_out = {31'b0, $signed(src1) < $signed(op_b)};
            `ALU_PASSB: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    assign link     = i_dec.pc + 32'd4;
    assign o_target = i_dec.pc + i_dec.imm;

    // BEQ takes on equal, BNE on not equal
    assign taken = i_dec.is_jal ||
                   (i_dec.is_branch && ((src1 == src2) != i_dec.branch_ne));
    assign o_redirect = i_dec.valid && taken;

    always_comb begin
        res_d.valid      = i_dec.valid;
        res_d.alu_result = i_dec.is_jal ? link : alu_out;
        res_d.store_data = src2;
        res_d.rd         = i_dec.rd;
        res_d.is_load    = i_dec.is_load;
        res_d.is_store   = i_dec.is_store;
        res_d.reg_write  = i_dec.reg_write;
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_res.valid     <= 1'b0;
            o_res.is_load   <= 1'b0;
            o_res.is_store  <= 1'b0;
            o_res.reg_write <= 1'b0;
        end else if (!i_hold) begin
            o_res <= res_d;
        end
    end

endmodule

// ==== decode/decode_stage.sv ====
`include "rv_pipe_consts.svh"

module decode_stage (
    input  logic                 clk,
    input  logic                 i_reset,
    input  rv_pipe_pkg::word_t   i_instr,
    input  rv_pipe_pkg::word_t   i_pc,
    input  logic                 i_hold,
    input  logic                 i_flush,
    input  rv_pipe_pkg::wb_t     i_wb,
    output rv_pipe_pkg::dec_ex_t o_dec
);
    import rv_pipe_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    reg_addr_t  rs1;
    reg_addr_t  rs2;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;
    alu_op_t    f3_op;
    logic       f3_ok;
    logic       legal;
    dec_ex_t    dec_d;

    assign opcode = i_instr[6:0];
    assign funct3 = i_instr[14:12];
    assign funct7 = i_instr[31:25];
    assign rs1    = i_instr[19:15];
    assign rs2    = i_instr[24:20];

    assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
    assign imm_s = {{20{i_instr[31]}}, i_instr[31:25], i_instr[11:7]};
    assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                    i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                    i_instr[30:21], 1'b0};

    reg_file reg_file_inst (
        .clk       (clk),
        .i_reset   (i_reset),
        .i_wb      (i_wb),
        .i_hold    (i_hold),
        .i_rs1     (rs1),
        .i_rs2     (rs2),
        .o_rs1_data(rs1_val),
        .o_rs2_data(rs2_val)
    );

    // Shared by register and immediate forms
    always_comb begin
        f3_ok = 1'b1;
        case (funct3)
            `F3_ADD: f3_op = `ALU_ADD;
            `F3_SLT: f3_op = `ALU_SLT;
            `F3_XOR: f3_op = `ALU_XOR;
            `F3_OR:  f3_op = `ALU_OR;
            `F3_AND: f3_op = `ALU_AND;
            default: begin
                f3_op = `ALU_ADD;
                f3_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec_d         = '0;
        dec_d.pc      = i_pc;
        dec_d.rs1     = rs1;
        dec_d.rs2     = rs2;
        dec_d.rs1_val = rs1_val;
        dec_d.rs2_val = rs2_val;
        dec_d.rd      = i_instr[11:7];
        dec_d.alu_op  = `ALU_ADD;
        legal         = 1'b1;
        case (opcode)
            `OP_REG: begin
                legal = f3_ok && (funct7 == `F7_BASE ||
                                  (funct7 == `F7_SUB && funct3 == `F3_ADD));
                dec_d.alu_op    = (funct7 == `F7_SUB) ? `ALU_SUB : f3_op;
                dec_d.reg_write = 1'b1;
            end
            `OP_IMM: begin
                legal           = f3_ok;
                dec_d.alu_op    = f3_op;
                dec_d.imm       = imm_i;
                dec_d.use_imm   = 1'b1;
                dec_d.reg_write = 1'b1;
            end
            `OP_LUI: begin
                dec_d.alu_op    = `ALU_PASSB;
                dec_d.imm       = imm_u;
                dec_d.use_imm   = 1'b1;
                dec_d.reg_write = 1'b1;
            end
            `OP_LOAD: begin
                legal           = (funct3 == `F3_WORD);
                dec_d.imm       = imm_i;
                dec_d.use_imm   = 1'b1;
                dec_d.is_load   = 1'b1;
                dec_d.reg_write = 1'b1;
            end
            `OP_STORE: begin
                legal          = (funct3 == `F3_WORD);
                dec_d.imm      = imm_s;
                dec_d.use_imm  = 1'b1;
                dec_d.is_store = 1'b1;
            end
            `OP_BRANCH: begin
                legal           = (funct3 == `F3_BEQ) || (funct3 == `F3_BNE);
                dec_d.alu_op    = `ALU_SUB;
                dec_d.imm       = imm_b;
                dec_d.is_branch = 1'b1;
                dec_d.branch_ne = (funct3 == `F3_BNE);
            end
            `OP_JAL: begin
                dec_d.imm       = imm_j;
                dec_d.is_jal    = 1'b1;
                dec_d.reg_write = 1'b1;
            end
            default: legal = 1'b0;
        endcase

        dec_d.valid = legal && !i_flush;
        if (!dec_d.valid) begin
            dec_d.reg_write = 1'b0;
            dec_d.is_load   = 1'b0;
            dec_d.is_store  = 1'b0;
            dec_d.is_branch = 1'b0;
            dec_d.is_jal    = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_dec.valid     <= 1'b0;
            o_dec.reg_write <= 1'b0;
            o_dec.is_load   <= 1'b0;
            o_dec.is_store  <= 1'b0;
            o_dec.is_branch <= 1'b0;
            o_dec.is_jal    <= 1'b0;
        end else if (!i_hold) begin
            o_dec <= dec_d;
        end
    end

    a_bubble_no_write: assert property (@(posedge clk) disable iff (i_reset)
        !o_dec.valid |-> !o_dec.reg_write);

endmodule

// ==== decode/reg_file.sv ====
module reg_file (
    input  logic                  clk,
    input  logic                  i_reset,
    input  rv_pipe_pkg::wb_t      i_wb,
    input  logic                  i_hold,
    input  rv_pipe_pkg::reg_addr_t i_rs1,
    input  rv_pipe_pkg::reg_addr_t i_rs2,
    output rv_pipe_pkg::word_t    o_rs1_data,
    output rv_pipe_pkg::word_t    o_rs2_data
);
    import rv_pipe_pkg::*;

    word_t regs [31:1];
    logic  wr_en;

    assign wr_en = i_wb.we && !i_hold && (i_wb.rd != '0);

    // x0 reads zero, a write in the same cycle passes straight through
    function automatic word_t read_port(reg_addr_t addr, logic we, wb_t wb, word_t stored);
        word_t value;
        if (addr == '0) begin
            value = '0;
        end else if (we && addr == wb.rd) begin
            value = wb.data;
        end else begin
            value = stored;
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (i_reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[i_wb.rd] <= i_wb.data;
        end
    end

    always_comb begin
        o_rs1_data = read_port(i_rs1, wr_en, i_wb, (i_rs1 == '0) ? '0 : regs[i_rs1]);
        o_rs2_data = read_port(i_rs2, wr_en, i_wb, (i_rs2 == '0) ? '0 : regs[i_rs2]);
    end

endmodule

// ==== rtl/fetch_control.sv ====
`include "rv_pipe_consts.svh"

module fetch_control (
    input  logic               clk,
    input  logic               i_reset,
    input  logic               i_acki,
    input  logic               i_mem_wait,
    input  logic               i_redirect,
    input  rv_pipe_pkg::word_t i_target,
    output rv_pipe_pkg::word_t o_pc,
    output logic               o_hold,
    output logic               o_flush
);
    import rv_pipe_pkg::*;

    logic  accept;
    logic  pending;
    word_t pending_target;

    assign accept = i_acki && !i_mem_wait;

    // Only an open data access stalls the stages; a missing fetch becomes a bubble
    assign o_hold  = i_mem_wait;
    assign o_flush = !i_acki || i_redirect || pending;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            o_pc    <= `RESET_PC;
            pending <= 1'b0;
        end else if (accept) begin
            pending <= 1'b0;
            if (i_redirect) begin
                o_pc <= i_target;
            end else if (pending) begin
                o_pc <= pending_target;
            end else begin
                o_pc <= o_pc + 32'd4;
            end
        end else if (i_redirect && !i_mem_wait) begin
            // Branch leaves execute while o_iad must stay put
            pending <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (i_redirect && !i_mem_wait && !i_acki) begin
            pending_target <= i_target;
        end
    end

    a_pc_aligned: assert property (@(posedge clk) disable iff (i_reset)
        o_pc[1:0] == 2'b00);

endmodule

// ==== common/rv_pipe_pkg.sv ====
package rv_pipe_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    // Encoded by the ALU_* macros
    typedef logic [3:0]  alu_op_t;

    // Decode to execute
    typedef struct packed {
        logic      valid;
        word_t     pc;
        reg_addr_t rs1;
        reg_addr_t rs2;
        word_t     rs1_val;
        word_t     rs2_val;
        word_t     imm;
        reg_addr_t rd;
        alu_op_t   alu_op;
        logic      use_imm;
        logic      is_load;
        logic      is_store;
        logic      is_branch;
        logic      branch_ne;
        logic      is_jal;
        logic      reg_write;
    } dec_ex_t;

    // Execute to result, alu_result doubles as address and link value
    typedef struct packed {
        logic      valid;
        word_t     alu_result;
        word_t     store_data;
        reg_addr_t rd;
        logic      is_load;
        logic      is_store;
        logic      reg_write;
    } ex_res_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } wb_t;

endpackage

// ==== common/rv_pipe_consts.svh ====
`ifndef RV_PIPE_CONSTS_SVH
`define RV_PIPE_CONSTS_SVH

// Major opcodes
`define OP_REG    7'b0110011
`define OP_IMM    7'b0010011
`define OP_LUI    7'b0110111
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111

// funct3 and funct7 values
`define F3_ADD    3'b000
`define F3_SLT    3'b010
`define F3_XOR    3'b100
`define F3_OR     3'b110
`define F3_AND    3'b111
`define F3_WORD   3'b010
`define F3_BEQ    3'b000
`define F3_BNE    3'b001
`define F7_BASE   7'b0000000
`define F7_SUB    7'b0100000

// ALU operations
`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_AND   4'd2
`define ALU_OR    4'd3
`define ALU_XOR   4'd4
`define ALU_SLT   4'd5
`define ALU_PASSB 4'd6

`define RESET_PC  32'h0000_0000

`endif
